//--- src.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/hazard_if.sv
verilog/issue_fifo.sv
verilog/dest_shadow.sv
verilog/hazard_detect.sv
verilog/stall_timer.sv
verilog/issue_ctrl.sv
verilog/issue_stage.sv
verif/tb_issue_stage.sv

//--- Bender.yml
package:
  name: issue_stage

sources:
  - verilog/isa_pkg.sv
  - verilog/pipe_pkg.sv
  - verilog/hazard_if.sv
  - verilog/issue_fifo.sv
  - verilog/dest_shadow.sv
  - verilog/hazard_detect.sv
  - verilog/stall_timer.sv
  - verilog/issue_ctrl.sv
  - verilog/issue_stage.sv
  - target: simulation
    files:
      - verif/tb_issue_stage.sv

//--- verif/tb_issue_stage.sv
`timescale 1ns/1ns

module tb_issue_stage import isa_pkg::*, pipe_pkg::*; ();

    localparam int num_directed    = 17;
    localparam int num_random      = 200;
    localparam int watchdog_cycles = (num_directed + num_random) * 4 + 200;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    instr_t in_instr;
    logic   credit_return;
    logic   out_valid;
    instr_t out_instr;

    integer seed = 32061;
    int     cyc = 0;
    int     credits = fifo_depth;
    int     errors = 0;
    int     issued = 0;
    int     gaps_checked = 0;
    instr_t sent_q[$];
    int     sent_cyc_q[$];

    // Last two issues, for the EX and MEM view of the next head
    logic   have_prev = 1'b0;
    logic   have_prev2 = 1'b0;
    instr_t prev_instr;
    instr_t prev2_instr;
    int     prev_cyc;
    int     prev2_cyc;
    instr_t exp_instr;
    int     exp_sent;
    int     issue_cyc;
    int     exp_gap;

    issue_stage u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_instr     (out_instr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic instr_t make_instr(input op_class_e op, input int rd, input int rs1,
                                          input int rs2, input int imm);
        instr_t ins;
        ins.op  = op;
        ins.rd  = rd[reg_addr_w-1:0];
        ins.rs1 = rs1[reg_addr_w-1:0];
        ins.rs2 = rs2[reg_addr_w-1:0];
        ins.imm = imm[imm_w-1:0];
        return ins;
    endfunction

    // Bubbles owed by head given what sits in EX and MEM
    function automatic int expected_bubbles(input instr_t head, input instr_t ex_i,
                                            input logic mem_v, input instr_t mem_i);
        int b;
        b = 0;
        if (ex_i.op == op_store && head.op == op_load && head.rs1 == ex_i.rs1 &&
            head.imm == ex_i.imm) begin
            b = 1;
        end
        if (mem_v && mem_i.op == op_load && mem_i.rd != 0 &&
            (mem_i.rd == head.rs1 || mem_i.rd == head.rs2)) begin
            b = 1;
        end
        if (ex_i.op == op_load && ex_i.rd != 0 &&
            (ex_i.rd == head.rs1 || ex_i.rd == head.rs2)) begin
            b = 2;
        end
        return b;
    endfunction

    // Called 2 ns after a rising edge, returns at the same phase
    task automatic send_instr(input instr_t ins);
        while (credits == 0) begin
            @(posedge clk);
            #2;
        end
        in_valid = 1'b1;
        in_instr = ins;
        sent_q.push_back(ins);
        sent_cyc_q.push_back(cyc);
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    // Credit bookkeeping, seen by the stimulus from the next edge on
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_valid) begin
                credits--;
            end
            if (credit_return) credits++;
            assert (credits <= fifo_depth) else begin
                errors++;
                $display("More credits returned than were spent at %0t", $time);
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            issue_cyc = cyc - 1; // Output register adds one cycle
            if (sent_q.size() == 0) begin
                errors++;
                $display("Output appeared with no instruction outstanding at %0t", $time);
            end else begin
                exp_instr = sent_q.pop_front();
                exp_sent  = sent_cyc_q.pop_front();
                issued++;
                assert (out_instr == exp_instr) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: got %h, expected %h", $time, out_instr,
                             exp_instr);
                end
                // Gap only defined when the head arrived right after the last issue
                if (have_prev && exp_sent <= prev_cyc) begin
                    exp_gap = expected_bubbles(exp_instr, prev_instr,
                                               have_prev2 && (prev2_cyc == prev_cyc - 1),
                                               prev2_instr);
                    gaps_checked++;
                    assert (issue_cyc == prev_cyc + 1 + exp_gap) else begin
                        errors++;
                        $display("CHECK FAILED at %0t: %h issued after %0d bubbles, expected %0d",
                                 $time, exp_instr, issue_cyc - prev_cyc - 1, exp_gap);
                    end
                end
                have_prev2  = have_prev;
                prev2_instr = prev_instr;
                prev2_cyc   = prev_cyc;
                have_prev   = 1'b1;
                prev_instr  = exp_instr;
                prev_cyc    = issue_cyc;
            end
        end
    end

    initial begin
        #(watchdog_cycles * 20);
        $display("Watchdog expired with %0d instructions outstanding", sent_q.size());
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int i = 0; i < 6; i++) begin
            send_instr(make_instr(op_alu, 4 + i, 0, 0, i)); // Independent ALU run
        end
        send_instr(make_instr(op_load, 5, 1, 0, 8));
        send_instr(make_instr(op_alu, 9, 5, 0, 0));         // Load in EX, 2 bubbles
        send_instr(make_instr(op_load, 6, 1, 0, 8));
        send_instr(make_instr(op_alu, 10, 0, 0, 0));
        send_instr(make_instr(op_alu, 11, 0, 6, 0));        // Load in MEM, 1 bubble
        send_instr(make_instr(op_store, 0, 7, 2, 16));
        send_instr(make_instr(op_load, 12, 7, 0, 16));      // Same base and offset
        send_instr(make_instr(op_store, 0, 7, 2, 16));
        send_instr(make_instr(op_load, 13, 7, 0, 20));
        send_instr(make_instr(op_load, 0, 1, 0, 4));
        send_instr(make_instr(op_alu, 14, 0, 0, 0));        // x0 never stalls

        for (int i = 0; i < num_random; i++) begin
            send_instr(make_instr(op_class_e'($unsigned($random(seed)) % 3),
                                  $unsigned($random(seed)) % 4,
                                  $unsigned($random(seed)) % 4,
                                  $unsigned($random(seed)) % 4,
                                  $unsigned($random(seed)) % 4));
            if ($unsigned($random(seed)) % 5 == 0) begin
                @(posedge clk);
                #2;
            end
        end

        while (sent_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        assert (credits == fifo_depth) else begin
            errors++;
            $display("Only %0d of %0d credits came back", credits, fifo_depth);
        end

        $display("Issued %0d instructions, %0d gaps checked, %0d errors", issued,
                 gaps_checked, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/issue_stage.sv
`timescale 1ns/1ns

module issue_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  instr_t in_instr,
    output logic   credit_return,
    output logic   out_valid,
    output instr_t out_instr
);

    hazard_if hz ();

    shadow_t               ex_stage;
    shadow_t               mem_stage;
    logic [imm_w-1:0]      ex_store_imm;
    logic [reg_addr_w-1:0] ex_store_base;
    logic                  timer_load;
    logic [bubbles_w-1:0]  timer_count;
    logic                  timer_busy;

    issue_fifo u_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .credit_return (credit_return),
        .hz            (hz.buffer)
    );

    dest_shadow u_shadow (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (hz.issue),
        .issue_instr (hz.head_instr),
        .ex_stage    (ex_stage),
        .mem_stage   (mem_stage),
        .wb_stage    ()
    );

    hazard_detect u_detect (
        .hz            (hz.det),
        .ex_stage      (ex_stage),
        .mem_stage     (mem_stage),
        .ex_store_imm  (ex_store_imm),
        .ex_store_base (ex_store_base)
    );

    stall_timer u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (timer_load),
        .count (timer_count),
        .busy  (timer_busy)
    );

    issue_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .hz          (hz.ctrl),
        .timer_load  (timer_load),
        .timer_count (timer_count),
        .timer_busy  (timer_busy)
    );

    // Base and offset of whatever enters EX, only read when it is a store
    always_ff @(posedge clk) begin
        if (hz.issue) begin
            ex_store_base <= hz.head_instr.rs1;
            ex_store_imm  <= hz.head_instr.imm;
            out_instr     <= hz.head_instr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= hz.issue; // EX always accepts
        end
    end

endmodule

//--- verilog/issue_ctrl.sv
`timescale 1ns/1ns

module issue_ctrl import pipe_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    hazard_if.ctrl               hz,
    output logic                 timer_load,
    output logic [bubbles_w-1:0] timer_count,
    input  logic                 timer_busy
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_issue;
        end else begin
            state <= state_nxt;
        end
    end

    // The cycle that detects the hazard is already the first bubble
    assign timer_count = hz.bubbles - 1'b1;

    always_comb begin
        state_nxt  = state;
        hz.issue   = 1'b0;
        timer_load = 1'b0;
        case (state)
            st_issue: begin
                if (hz.head_valid) begin
                    if (hz.bubbles == '0) begin
                        hz.issue = 1'b1;
                    end else begin
                        timer_load = 1'b1;
                        state_nxt  = st_stall;
                    end
                end
            end
            st_stall: begin
                // Head cannot leave while stalled, no re-check needed
                if (!timer_busy) begin
                    hz.issue  = 1'b1;
                    state_nxt = st_issue;
                end
            end
            default: state_nxt = st_issue;
        endcase
    end

endmodule

//--- verilog/stall_timer.sv
`timescale 1ns/1ns

module stall_timer import pipe_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  logic [bubbles_w-1:0] count,
    output logic                 busy
);

    logic [bubbles_w-1:0] remaining;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= count;
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    assign busy = (remaining != '0);

endmodule

//--- verilog/hazard_detect.sv
`timescale 1ns/1ns

module hazard_detect import isa_pkg::*, pipe_pkg::*; (
    hazard_if.det                hz,
    input  shadow_t              ex_stage,
    input  shadow_t              mem_stage,
    input  logic [imm_w-1:0]     ex_store_imm,
    input  logic [reg_addr_w-1:0] ex_store_base
);

    logic load_ex_hit;
    logic load_mem_hit;
    logic mem_order_hit;

    // x0 is never a real destination
    always_comb begin
        load_ex_hit = (ex_stage.op == op_load) && (ex_stage.rd != '0) &&
                      ((ex_stage.rd == hz.head_instr.rs1) ||
                       (ex_stage.rd == hz.head_instr.rs2));

        load_mem_hit = (mem_stage.op == op_load) && (mem_stage.rd != '0) &&
                       ((mem_stage.rd == hz.head_instr.rs1) ||
                        (mem_stage.rd == hz.head_instr.rs2));

        // Same base register and offset, address itself not compared
        mem_order_hit = (hz.head_instr.op == op_load) && (ex_stage.op == op_store) &&
                        (hz.head_instr.rs1 == ex_store_base) &&
                        (hz.head_instr.imm == ex_store_imm);
    end

    // Largest applicable count wins
    always_comb begin
        hz.bubbles = '0;
        if (mem_order_hit && (mem_order_bubbles > hz.bubbles)) begin
            hz.bubbles = mem_order_bubbles;
        end
        if (load_mem_hit && (load_mem_bubbles > hz.bubbles)) begin
            hz.bubbles = load_mem_bubbles;
        end
        if (load_ex_hit && (load_ex_bubbles > hz.bubbles)) begin
            hz.bubbles = load_ex_bubbles;
        end
    end

endmodule

//--- verilog/dest_shadow.sv
`timescale 1ns/1ns

module dest_shadow import isa_pkg::*, pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    issue,
    input  instr_t  issue_instr,
    output shadow_t ex_stage,
    output shadow_t mem_stage,
    output shadow_t wb_stage
);

    shadow_t ex_next;

    // Empty slot enters EX when nothing issues
    always_comb begin
        if (issue) begin
            ex_next.rd = issue_instr.rd;
            ex_next.op = issue_instr.op;
        end else begin
            ex_next = shadow_empty;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_stage  <= shadow_empty;
            mem_stage <= shadow_empty;
            wb_stage  <= shadow_empty;
        end else begin
            ex_stage  <= ex_next;
            mem_stage <= ex_stage;
            wb_stage  <= mem_stage;
        end
    end

endmodule

//--- verilog/issue_fifo.sv
`timescale 1ns/1ns

module issue_fifo import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  instr_t   in_instr,
    output logic     credit_return,
    hazard_if.buffer hz
);

    instr_t           mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;

    // Decoder only sends while holding a credit, so no full check here
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_instr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1; // Wraps at fifo_depth
            end
            if (hz.issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({in_valid, hz.issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign hz.head_valid = (count != '0);
    assign hz.head_instr = mem[rd_ptr];

    // Freed entry goes straight back to the decoder
    assign credit_return = hz.issue;

endmodule

//--- verilog/hazard_if.sv
`timescale 1ns/1ns

interface hazard_if import isa_pkg::*, pipe_pkg::*; ();

    logic                 head_valid;
    instr_t               head_instr;
    logic [bubbles_w-1:0] bubbles;
    logic                 issue;       // Pop strobe

    modport det (
        input  head_instr,
        output bubbles
    );

    modport ctrl (
        input  head_valid,
        input  bubbles,
        output issue
    );

    modport buffer (
        output head_valid,
        output head_instr,
        input  issue
    );

endinterface

//--- verilog/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    localparam int fifo_depth = 4;
    localparam int ptr_w      = 2;
    localparam int bubbles_w  = 2;

    // Bubble counts per hazard kind
    localparam logic [bubbles_w-1:0] load_ex_bubbles   = 2'd2;
    localparam logic [bubbles_w-1:0] load_mem_bubbles  = 2'd1;
    localparam logic [bubbles_w-1:0] mem_order_bubbles = 2'd1;

    // What one downstream stage holds
    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        op_class_e             op;
    } shadow_t;

    localparam shadow_t shadow_empty = '{rd: '0, op: op_none};

    typedef enum logic {
        st_issue,
        st_stall
    } ctrl_state_e;

endpackage

//--- verilog/isa_pkg.sv
package isa_pkg;

    localparam int reg_addr_w = 5;
    localparam int imm_w      = 12; // Low immediate bits used for address matching

    typedef enum logic [1:0] {
        op_alu,
        op_load,
        op_store,
        op_none
    } op_class_e;

    // One decoded instruction as seen by the issue stage
    typedef struct packed {
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        op_class_e             op;
        logic [imm_w-1:0]      imm;
    } instr_t;

endpackage
